// ==== all.f ====
+incdir+.
cpu_pkg.sv
seq_ctl_if.sv
seq_fsm.sv
pc_counter.sv
alu_datapath.sv
cpu_core.sv
cpu_sva.sv
cpu_tb.sv

// ==== alu_datapath.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module alu_datapath import cpu_pkg::*; (
	input  logic               clk_i,
	input  logic               rst_n_i,
	seq_ctl_if.dp              ctl,
	input  logic [`CPU_DW-1:0] rdata_i,
	input  logic [`CPU_AW-1:0] pc_i,
	output logic [`CPU_AW-1:0] addr_o,
	output logic [`CPU_DW-1:0] wdata_o,
	output logic               we_o,
	output logic [`CPU_DW-1:0] adl_o
);

logic [`CPU_DW-1:0] a_q, x_q, y_q, adl_q, adh_q;
flags_t p_q;
logic [`CPU_DW-1:0] src_a, src_b, b_op, alu_y;
logic [`CPU_DW:0] sum;
logic cin;
flags_t flags_new;

always_comb begin
	case (ctl.a_sel)
	ASEL_A:	src_a = a_q;
	ASEL_X:	src_a = x_q;
	ASEL_Y:	src_a = y_q;
	default:	src_a = '0;
	endcase
end

assign src_b = (ctl.b_sel == BSEL_ONE) ? {{(`CPU_DW-1){1'b0}}, 1'b1} : rdata_i;
assign b_op = (ctl.alu_func == ALU_SUB) ? ~src_b : src_b;	// A + ~B + C
assign cin = ctl.cin_clr ? (ctl.alu_func == ALU_SUB) : p_q[`STATUS_C];
assign sum = {1'b0, src_a} + {1'b0, b_op} + {{`CPU_DW{1'b0}}, cin};

always_comb begin
	case (ctl.alu_func)
	ALU_TXA:	alu_y = src_a;
	ALU_ADD, ALU_SUB:	alu_y = sum[`CPU_DW-1:0];
	ALU_AND:	alu_y = src_a & src_b;
	ALU_ORA:	alu_y = src_a | src_b;
	ALU_EOR:	alu_y = src_a ^ src_b;
	default:	alu_y = src_b;
	endcase
	flags_new = '0;
	flags_new[`STATUS_N] = alu_y[`CPU_DW-1];
	flags_new[`STATUS_Z] = (alu_y == '0);
	flags_new[`STATUS_C] = sum[`CPU_DW];	// Set means no borrow on SUB
	// Operands of like sign giving a result of the other sign
	flags_new[`STATUS_V] = (src_a[`CPU_DW-1] == b_op[`CPU_DW-1]) &&
		(alu_y[`CPU_DW-1] != src_a[`CPU_DW-1]);
end

always_ff @(posedge clk_i) begin
	if (!rst_n_i) begin
		a_q <= '0;
		x_q <= '0;
		y_q <= '0;
		adl_q <= '0;
		adh_q <= '0;
		p_q <= '0;
	end else begin
		case (ctl.dst)
		DST_A:	a_q <= alu_y;
		DST_X:	x_q <= alu_y;
		DST_Y:	y_q <= alu_y;
		DST_ADL:	adl_q <= alu_y;
		DST_ADH:	adh_q <= alu_y;
		default:	;
		endcase
		p_q <= ((p_q & ~ctl.flag_mask) | (flags_new & ctl.flag_mask) | ctl.flag_set) &
			~ctl.flag_clr;
	end
end

assign addr_o = (ctl.addr_sel == ADDR_AD) ? {adh_q, adl_q} : pc_i;
assign wdata_o = alu_y;
assign we_o = (ctl.dst == DST_BUS);
assign adl_o = adl_q;	// Low byte of a jump target

endmodule

// ==== cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define CPU_DW 8
`define CPU_AW 16
`define CPU_RESET_PC 16'h0200

// Flag positions in the status byte
`define STATUS_C 0
`define STATUS_Z 1
`define STATUS_V 6
`define STATUS_N 7

`define OPC_LDA_IMM 8'hA9
`define OPC_LDA_ZP 8'hA5
`define OPC_LDA_ABS 8'hAD
`define OPC_LDX_IMM 8'hA2
`define OPC_LDX_ZP 8'hA6
`define OPC_LDX_ABS 8'hAE
`define OPC_LDY_IMM 8'hA0
`define OPC_LDY_ZP 8'hA4
`define OPC_LDY_ABS 8'hAC
`define OPC_STA_ZP 8'h85
`define OPC_STA_ABS 8'h8D
`define OPC_STX_ZP 8'h86
`define OPC_STX_ABS 8'h8E
`define OPC_STY_ZP 8'h84
`define OPC_STY_ABS 8'h8C
`define OPC_ADC_IMM 8'h69
`define OPC_ADC_ZP 8'h65
`define OPC_ADC_ABS 8'h6D
`define OPC_SBC_IMM 8'hE9
`define OPC_SBC_ZP 8'hE5
`define OPC_SBC_ABS 8'hED
`define OPC_AND_IMM 8'h29
`define OPC_AND_ZP 8'h25
`define OPC_AND_ABS 8'h2D
`define OPC_ORA_IMM 8'h09
`define OPC_ORA_ZP 8'h05
`define OPC_ORA_ABS 8'h0D
`define OPC_EOR_IMM 8'h49
`define OPC_EOR_ZP 8'h45
`define OPC_EOR_ABS 8'h4D
`define OPC_INX 8'hE8
`define OPC_INY 8'hC8
`define OPC_DEX 8'hCA
`define OPC_DEY 8'h88
`define OPC_TAX 8'hAA
`define OPC_TXA 8'h8A
`define OPC_CLC 8'h18
`define OPC_SEC 8'h38
`define OPC_JMP_ABS 8'h4C

`endif

// ==== cpu_core.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_core (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  logic               rdy_i,
	input  logic [`CPU_DW-1:0] rdata_i,
	output logic [`CPU_AW-1:0] addr_o,
	output logic [`CPU_DW-1:0] wdata_o,
	output logic               we_o
);

logic pc_inc, pc_load;
logic [`CPU_AW-1:0] pc;
logic [`CPU_DW-1:0] adl;

seq_ctl_if u_ctl ();

seq_fsm u_seq_fsm (
	.clk_i     (clk_i),
	.rst_n_i   (rst_n_i),
	.rdy_i     (rdy_i),
	.rdata_i   (rdata_i),
	.ctl       (u_ctl.seq),
	.pc_inc_o  (pc_inc),
	.pc_load_o (pc_load)
);

pc_counter u_pc_counter (
	.clk_i     (clk_i),
	.rst_n_i   (rst_n_i),
	.pc_inc_i  (pc_inc),
	.pc_load_i (pc_load),
	.rdata_i   (rdata_i),
	.adl_i     (adl),
	.pc_o      (pc)
);

alu_datapath u_alu_datapath (
	.clk_i   (clk_i),
	.rst_n_i (rst_n_i),
	.ctl     (u_ctl.dp),
	.rdata_i (rdata_i),
	.pc_i    (pc),
	.addr_o  (addr_o),
	.wdata_o (wdata_o),
	.we_o    (we_o),
	.adl_o   (adl)
);

endmodule

// ==== cpu_pkg.sv ====
`include "cpu_consts.svh"

package cpu_pkg;

typedef logic [`CPU_DW-1:0] flags_t;	// Same layout as the status byte

typedef enum logic [4:0] {
	OP_NOP, OP_LDA, OP_LDX, OP_LDY, OP_STA, OP_STX, OP_STY,
	OP_ADC, OP_SBC, OP_AND, OP_ORA, OP_EOR,
	OP_INX, OP_INY, OP_DEX, OP_DEY,
	OP_TAX, OP_TXA, OP_CLC, OP_SEC, OP_JMP
} op_e;

typedef enum logic [1:0] {
	Imp, Imm, Zp, Abs
} mode_e;

typedef enum logic [2:0] {
	ALU_TXA, ALU_TXB, ALU_ADD, ALU_SUB, ALU_AND, ALU_ORA, ALU_EOR
} alu_func_e;

typedef enum logic [1:0] {
	ASEL_ZERO, ASEL_A, ASEL_X, ASEL_Y
} a_sel_e;

typedef enum logic {
	BSEL_BUS, BSEL_ONE
} b_sel_e;

typedef enum logic [2:0] {
	DST_NONE, DST_A, DST_X, DST_Y, DST_ADL, DST_ADH, DST_BUS
} dst_sel_e;

typedef enum logic {
	ADDR_PC, ADDR_AD	// AD is the {ADH, ADL} latch
} addr_sel_e;

typedef enum logic [1:0] {
	Fetch, Decode, ReadH, Execute
} seq_state_e;

typedef struct packed {
	op_e op;
	mode_e mode;
} decode_t;

endpackage

// ==== cpu_sva.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_sva import cpu_pkg::*; (
	input logic               clk_i,
	input logic               rst_n_i,
	input logic               rdy_i,
	input logic [`CPU_AW-1:0] addr_i,
	input logic [`CPU_DW-1:0] wdata_i,
	input logic               we_i,
	input seq_state_e         state_i
);

int unsigned fail_cnt = 0;	// Failed properties so far

// Writes only in the Execute step and never in reset
we_only_execute: assert property (@(posedge clk_i)
	(!rst_n_i || state_i != Execute) |-> !we_i)
	else begin
		fail_cnt++;
		$error("we_o high outside Execute or during reset");
	end

bus_hold_on_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
	!rdy_i |=> $stable(addr_i) && $stable(wdata_i) && $stable(we_i))
	else begin
		fail_cnt++;
		$error("Bus outputs moved across a wait state");
	end

first_fetch_addr: assert property (@(posedge clk_i)
	$rose(rst_n_i) |-> addr_i == `CPU_RESET_PC)
	else begin
		fail_cnt++;
		$error("First address after reset is %h", addr_i);
	end

endmodule

// ==== cpu_tb.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_tb;

typedef struct {
	string name;
	logic [`CPU_AW-1:0] addr;
	logic [`CPU_DW-1:0] data;
} store_t;

logic sys_clk;
logic rst_n;
logic rdy;
logic [`CPU_DW-1:0] rdata;
logic [`CPU_AW-1:0] addr;
logic [`CPU_DW-1:0] wdata;
logic we;
logic [`CPU_DW-1:0] mem [0:65535];
logic [15:0] lfsr_q = 16'd55980;
store_t exp_q[$];
store_t head;
logic [`CPU_AW-1:0] asm_pc = `CPU_RESET_PC;
logic [`CPU_AW-1:0] zp_ptr = 16'h0010;	// Operand bytes
logic [`CPU_AW-1:0] abs_ptr = 16'h2000;
logic [`CPU_AW-1:0] st_zp = 16'h0080;	// Store targets
logic [`CPU_AW-1:0] st_abs = 16'h3000;
int n_instr = 0;
logic [`CPU_DW-1:0] rf [0:2];	// A, X, Y as the program leaves them
logic carry;

// Rows A, X, Y and columns imm, zp, abs
logic [7:0] ld_opc [0:2][0:2] = '{
	'{`OPC_LDA_IMM, `OPC_LDA_ZP, `OPC_LDA_ABS},
	'{`OPC_LDX_IMM, `OPC_LDX_ZP, `OPC_LDX_ABS},
	'{`OPC_LDY_IMM, `OPC_LDY_ZP, `OPC_LDY_ABS}};
logic [7:0] st_opc [0:2][0:1] = '{
	'{`OPC_STA_ZP, `OPC_STA_ABS},
	'{`OPC_STX_ZP, `OPC_STX_ABS},
	'{`OPC_STY_ZP, `OPC_STY_ABS}};
logic [7:0] lg_opc [0:2][0:1] = '{
	'{`OPC_AND_ZP, `OPC_AND_ABS},
	'{`OPC_ORA_ZP, `OPC_ORA_ABS},
	'{`OPC_EOR_ZP, `OPC_EOR_ABS}};

cpu_core u_cpu_core (
	.clk_i   (sys_clk),
	.rst_n_i (rst_n),
	.rdy_i   (rdy),
	.rdata_i (rdata),
	.addr_o  (addr),
	.wdata_o (wdata),
	.we_o    (we)
);

bind cpu_core cpu_sva u_cpu_sva (
	.clk_i   (clk_i),
	.rst_n_i (rst_n_i),
	.rdy_i   (rdy_i),
	.addr_i  (addr_o),
	.wdata_i (wdata_o),
	.we_i    (we_o),
	.state_i (u_seq_fsm.state_q)
);

assign rdata = mem[addr];	// Zero-latency memory

// Taps 16, 14, 13, 11
function automatic logic lfsr_bit();
	logic fb;
	fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
	lfsr_q = {lfsr_q[14:0], fb};
	return fb;
endfunction

function automatic logic [7:0] rand_byte();
	logic [7:0] v;
	for (int i = 0; i < 8; i++)
		v = {v[6:0], lfsr_bit()};
	return v;
endfunction

task automatic emit(input logic [7:0] b);
	mem[asm_pc] = b;
	asm_pc++;
endtask

task automatic instr(input logic [7:0] opc, input int nbytes, input logic [15:0] opd);
	emit(opc);
	if (nbytes > 1)
		emit(opd[7:0]);
	if (nbytes > 2)
		emit(opd[15:8]);
	n_instr++;
endtask

// Mode 0 imm, 1 zp, 2 abs
task automatic place(input int m, input logic [7:0] v, output logic [15:0] opd);
	case (m)
	0:	opd = {8'h00, v};
	1: begin
		opd = zp_ptr;
		zp_ptr++;
	end
	default: begin
		opd = abs_ptr;
		abs_ptr++;
	end
	endcase
	if (m != 0)
		mem[opd] = v;
endtask

task automatic store(input int r, input logic use_abs, input string name);
	store_t s;
	s.addr = use_abs ? st_abs : st_zp;
	if (use_abs)
		st_abs++;
	else
		st_zp++;
	instr(st_opc[r][use_abs], use_abs ? 3 : 2, s.addr);
	s.name = name;
	s.data = rf[r];
	exp_q.push_back(s);
endtask

initial begin
	sys_clk = 1'b0;
	forever #2 sys_clk = ~sys_clk;
end

always @(posedge sys_clk) begin
	#1;
	rdy = ~(lfsr_bit() & lfsr_bit());	// Low on about a quarter of cycles
end

always @(posedge sys_clk) begin
	if (rst_n && rdy && we) begin
		mem[addr] <= wdata;
		if (exp_q.size() == 0) begin
			$display("A store to %h came after the last expected store", addr);
			$display("Regression failed");
			$fatal(1, "Unexpected store");
		end else begin
			head = exp_q.pop_front();
			check_store: assert (addr == head.addr && wdata == head.data)
			else begin
				$display("ERR %s expected %h at %h, actual %h at %h",
					head.name, head.data, head.addr, wdata, addr);
				$display("Regression failed");
				$fatal(1, "Store mismatch");
			end
		end
	end
end

always @(negedge sys_clk) begin
	if (u_cpu_core.u_cpu_sva.fail_cnt != 0) begin
		$display("Regression failed");
		$fatal(1, "A bus property of the core failed");
	end
end

initial begin
	#1;	// Program is assembled at time 0
	#(n_instr * 4 * 8 * 4 + 40);
	$display("Timeout: the expected stores did not finish");
	$display("Regression failed");
	$fatal(1, "Watchdog expired");
end

initial begin
	int r, m, k, i, t;
	logic [7:0] a, b;
	logic [15:0] opd, target;
	rst_n = 1'b0;
	rdy = 1'b1;
	for (i = 0; i < 65536; i++)
		mem[i] = i[15:8] ^ i[7:0] ^ 8'hA5;
	for (r = 0; r < 3; r++) begin
		for (m = 0; m < 3; m++) begin
			a = rand_byte();
			place(m, a, opd);
			instr(ld_opc[r][m], (m == 2) ? 3 : 2, opd);
			rf[r] = a;
			store(r, m[0], "load_store");
		end
	end
	for (k = 0; k < 4; k++) begin	// Even k adds, odd k subtracts
		carry = lfsr_bit();
		a = rand_byte();
		b = rand_byte();
		instr(carry ? `OPC_SEC : `OPC_CLC, 1, 16'h0);
		instr(`OPC_LDA_IMM, 2, {8'h00, a});
		instr(k[0] ? `OPC_SBC_IMM : `OPC_ADC_IMM, 2, {8'h00, b});
		if (k[0])
			t = int'(a) - int'(b) - 1 + int'(carry);
		else
			t = int'(a) + int'(b) + int'(carry);
		rf[0] = t[7:0];
		carry = k[0] ? (t >= 0) : (t > 255);	// Borrow shows as carry clear
		store(0, 1'b0, k[0] ? "sbc" : "adc");
		instr(`OPC_ADC_IMM, 2, 16'h0);
		t = int'(rf[0]) + int'(carry);
		rf[0] = t[7:0];
		store(0, 1'b0, "carry_out");
	end
	for (k = 0; k < 6; k++) begin
		a = rand_byte();
		b = rand_byte();
		m = 1 + (k % 2);
		instr(`OPC_LDA_IMM, 2, {8'h00, a});
		place(m, b, opd);
		instr(lg_opc[k / 2][m - 1], (m == 2) ? 3 : 2, opd);
		case (k / 2)
		0:	rf[0] = a & b;
		1:	rf[0] = a | b;
		default:	rf[0] = a ^ b;
		endcase
		store(0, 1'b1, "logic");
	end
	a = rand_byte();
	b = rand_byte();
	instr(`OPC_LDA_IMM, 2, {8'h00, a});
	instr(`OPC_TAX, 1, 16'h0);
	instr(`OPC_INX, 1, 16'h0);
	instr(`OPC_INX, 1, 16'h0);
	instr(`OPC_DEX, 1, 16'h0);
	rf[1] = a + 8'd1;
	store(1, 1'b0, "count_x");
	instr(`OPC_LDY_IMM, 2, {8'h00, b});
	instr(`OPC_INY, 1, 16'h0);
	instr(`OPC_INY, 1, 16'h0);
	instr(`OPC_DEY, 1, 16'h0);
	rf[2] = b + 8'd1;
	store(2, 1'b1, "count_y");
	instr(`OPC_TXA, 1, 16'h0);
	rf[0] = rf[1];
	store(0, 1'b0, "txa");
	target = asm_pc + 16'd6;
	instr(`OPC_JMP_ABS, 3, target);
	instr(`OPC_STA_ABS, 3, 16'h3FFF);	// Trap, skipped by the jump
	store(0, 1'b1, "jump");
	target = asm_pc;
	instr(`OPC_JMP_ABS, 3, target);	// Park on a self loop
	repeat (3) @(posedge sys_clk);
	#1;
	rst_n = 1'b1;
	while (exp_q.size() != 0)
		@(posedge sys_clk);
	@(negedge sys_clk);
	if (u_cpu_core.u_cpu_sva.fail_cnt != 0) begin
		$display("Regression failed");
		$fatal(1, "A bus property of the core failed");
	end else begin
		$display("Regression passed");
		$finish;
	end
end

endmodule

// ==== pc_counter.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module pc_counter (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  logic               pc_inc_i,
	input  logic               pc_load_i,
	input  logic [`CPU_DW-1:0] rdata_i,
	input  logic [`CPU_DW-1:0] adl_i,
	output logic [`CPU_AW-1:0] pc_o
);

always_ff @(posedge clk_i) begin
	if (!rst_n_i)
		pc_o <= `CPU_RESET_PC;
	else if (pc_load_i)
		pc_o <= {rdata_i, adl_i};	// Jump target, high byte from the bus
	else if (pc_inc_i)
		pc_o <= pc_o + 1'b1;
end

endmodule

// ==== seq_ctl_if.sv ====
`timescale 1ns/1ps

interface seq_ctl_if import cpu_pkg::*; ();

alu_func_e alu_func;
a_sel_e a_sel;
b_sel_e b_sel;
dst_sel_e dst;
addr_sel_e addr_sel;
logic cin_clr;	// Carry-in from the op, not from C
flags_t flag_mask;
flags_t flag_set;
flags_t flag_clr;

modport seq (
	output alu_func, a_sel, b_sel, dst, addr_sel,
	output cin_clr, flag_mask, flag_set, flag_clr
);

modport dp (
	input alu_func, a_sel, b_sel, dst, addr_sel,
	input cin_clr, flag_mask, flag_set, flag_clr
);

endinterface

// ==== seq_fsm.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module seq_fsm import cpu_pkg::*; (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  logic               rdy_i,
	input  logic [`CPU_DW-1:0] rdata_i,
	seq_ctl_if.seq             ctl,
	output logic               pc_inc_o,
	output logic               pc_load_o
);

localparam flags_t MASK_C = flags_t'(1) << `STATUS_C;
localparam flags_t MASK_NZ = (flags_t'(1) << `STATUS_N) | (flags_t'(1) << `STATUS_Z);
localparam flags_t MASK_NZCV = MASK_NZ | MASK_C | (flags_t'(1) << `STATUS_V);

seq_state_e state_q, state_d;
logic [`CPU_DW-1:0] ir_q;
decode_t dec;
logic execute;

always_ff @(posedge clk_i) begin
	if (!rst_n_i) begin
		state_q <= Fetch;
		ir_q <= '0;
	end else if (rdy_i) begin
		state_q <= state_d;
		if (state_q == Fetch)
			ir_q <= rdata_i;	// Opcode byte
	end
end

always_comb begin
	dec.op = OP_NOP;
	case (ir_q)
	`OPC_LDA_IMM, `OPC_LDA_ZP, `OPC_LDA_ABS:	dec.op = OP_LDA;
	`OPC_LDX_IMM, `OPC_LDX_ZP, `OPC_LDX_ABS:	dec.op = OP_LDX;
	`OPC_LDY_IMM, `OPC_LDY_ZP, `OPC_LDY_ABS:	dec.op = OP_LDY;
	`OPC_STA_ZP, `OPC_STA_ABS:	dec.op = OP_STA;
	`OPC_STX_ZP, `OPC_STX_ABS:	dec.op = OP_STX;
	`OPC_STY_ZP, `OPC_STY_ABS:	dec.op = OP_STY;
	`OPC_ADC_IMM, `OPC_ADC_ZP, `OPC_ADC_ABS:	dec.op = OP_ADC;
	`OPC_SBC_IMM, `OPC_SBC_ZP, `OPC_SBC_ABS:	dec.op = OP_SBC;
	`OPC_AND_IMM, `OPC_AND_ZP, `OPC_AND_ABS:	dec.op = OP_AND;
	`OPC_ORA_IMM, `OPC_ORA_ZP, `OPC_ORA_ABS:	dec.op = OP_ORA;
	`OPC_EOR_IMM, `OPC_EOR_ZP, `OPC_EOR_ABS:	dec.op = OP_EOR;
	`OPC_INX:	dec.op = OP_INX;
	`OPC_INY:	dec.op = OP_INY;
	`OPC_DEX:	dec.op = OP_DEX;
	`OPC_DEY:	dec.op = OP_DEY;
	`OPC_TAX:	dec.op = OP_TAX;
	`OPC_TXA:	dec.op = OP_TXA;
	`OPC_CLC:	dec.op = OP_CLC;
	`OPC_SEC:	dec.op = OP_SEC;
	`OPC_JMP_ABS:	dec.op = OP_JMP;
	default:	;
	endcase
	// Addressing mode follows the column of the 6502 opcode map
	case (ir_q[4:2])
	3'b000:	dec.mode = Imm;
	3'b001:	dec.mode = Zp;
	3'b010:	dec.mode = ir_q[0] ? Imm : Imp;
	3'b011:	dec.mode = Abs;
	default:	dec.mode = Imp;
	endcase
	if (dec.op == OP_NOP)
		dec.mode = Imp;	// Unknown bytes take one cycle pair
end

always_comb begin
	ctl.alu_func = ALU_TXB;
	ctl.a_sel = ASEL_ZERO;
	ctl.b_sel = BSEL_BUS;
	ctl.dst = DST_NONE;
	ctl.addr_sel = ADDR_PC;
	ctl.cin_clr = 1'b0;
	ctl.flag_mask = '0;
	ctl.flag_set = '0;
	ctl.flag_clr = '0;
	pc_inc_o = 1'b0;
	pc_load_o = 1'b0;
	execute = 1'b0;
	state_d = state_q;

	case (state_q)
	Fetch: begin
		pc_inc_o = 1'b1;
		ctl.alu_func = ALU_TXA;	// Zero into ADH
		ctl.dst = DST_ADH;
		state_d = Decode;
	end
	Decode: begin
		case (dec.mode)
		Imp: begin
			execute = 1'b1;
			state_d = Fetch;
		end
		Imm: begin
			pc_inc_o = 1'b1;
			execute = 1'b1;
			state_d = Fetch;
		end
		default: begin
			pc_inc_o = 1'b1;
			ctl.dst = DST_ADL;	// Operand low byte
			state_d = (dec.mode == Zp) ? Execute : ReadH;
		end
		endcase
	end
	ReadH: begin
		ctl.dst = DST_ADH;	// Operand high byte
		state_d = Fetch;
		if (dec.op == OP_JMP)
			pc_load_o = 1'b1;
		else begin
			pc_inc_o = 1'b1;
			state_d = Execute;
		end
	end
	Execute: begin
		ctl.addr_sel = ADDR_AD;
		execute = 1'b1;
		state_d = Fetch;
	end
	default:	state_d = Fetch;
	endcase

	if (execute) begin
		case (dec.op)
		OP_LDA, OP_LDX, OP_LDY: begin
			ctl.dst = (dec.op == OP_LDA) ? DST_A : ((dec.op == OP_LDX) ? DST_X : DST_Y);
			ctl.flag_mask = MASK_NZ;
		end
		OP_STA, OP_STX, OP_STY: begin
			ctl.alu_func = ALU_TXA;
			ctl.a_sel = (dec.op == OP_STA) ? ASEL_A : ((dec.op == OP_STX) ? ASEL_X : ASEL_Y);
			ctl.dst = DST_BUS;
		end
		OP_ADC, OP_SBC: begin
			ctl.alu_func = (dec.op == OP_ADC) ? ALU_ADD : ALU_SUB;
			ctl.a_sel = ASEL_A;
			ctl.dst = DST_A;
			ctl.flag_mask = MASK_NZCV;
		end
		OP_AND, OP_ORA, OP_EOR: begin
			ctl.alu_func = (dec.op == OP_AND) ? ALU_AND :
				((dec.op == OP_ORA) ? ALU_ORA : ALU_EOR);
			ctl.a_sel = ASEL_A;
			ctl.dst = DST_A;
			ctl.flag_mask = MASK_NZ;
		end
		OP_INX, OP_INY, OP_DEX, OP_DEY: begin
			ctl.alu_func = (dec.op inside {OP_INX, OP_INY}) ? ALU_ADD : ALU_SUB;
			ctl.a_sel = (dec.op inside {OP_INX, OP_DEX}) ? ASEL_X : ASEL_Y;
			ctl.b_sel = BSEL_ONE;
			ctl.cin_clr = 1'b1;	// Plain step of one
			ctl.dst = (dec.op inside {OP_INX, OP_DEX}) ? DST_X : DST_Y;
			ctl.flag_mask = MASK_NZ;
		end
		OP_TAX: begin
			ctl.alu_func = ALU_TXA;
			ctl.a_sel = ASEL_A;
			ctl.dst = DST_X;
			ctl.flag_mask = MASK_NZ;
		end
		OP_TXA: begin
			ctl.alu_func = ALU_TXA;
			ctl.a_sel = ASEL_X;
			ctl.dst = DST_A;
			ctl.flag_mask = MASK_NZ;
		end
		OP_CLC:	ctl.flag_clr = MASK_C;
		OP_SEC:	ctl.flag_set = MASK_C;
		default:	;	// NOP, and JMP is done in ReadH
		endcase
	end

	if (!rdy_i) begin	// Wait state
		pc_inc_o = 1'b0;
		pc_load_o = 1'b0;
		ctl.flag_mask = '0;
		ctl.flag_set = '0;
		ctl.flag_clr = '0;
		if (ctl.dst != DST_BUS)
			ctl.dst = DST_NONE;	// Bus write stays up so the bus cycle holds
	end
end

endmodule
